/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int word_w = 16;
  localparam int reg_sel_w = 3;

  // selector 7 addresses the program counter of the active bank
  localparam logic [reg_sel_w-1:0] reg_pc = 3'd7;

  // opcodes, instr[15:12]
  localparam logic [3:0] op_alu = 4'd0;
  localparam logic [3:0] op_ldi = 4'd1;
  localparam logic [3:0] op_ld = 4'd2;
  localparam logic [3:0] op_st = 4'd3;
  localparam logic [3:0] op_skp = 4'd4;
  localparam logic [3:0] op_hlt = 4'd5;
  localparam logic [3:0] op_rti = 4'd6;
  localparam logic [3:0] op_nop = 4'd7;

  // alu functions, instr[2:0]
  localparam logic [2:0] f_add = 3'd0;
  localparam logic [2:0] f_sub = 3'd1;
  localparam logic [2:0] f_and = 3'd2;
  localparam logic [2:0] f_or = 3'd3;
  localparam logic [2:0] f_xor = 3'd4;
  localparam logic [2:0] f_shl = 3'd5;
  localparam logic [2:0] f_shr = 3'd6;
  localparam logic [2:0] f_pass = 3'd7;

  localparam logic [2:0] st_fetch = 3'd0;
  localparam logic [2:0] st_fetchm = 3'd1;
  localparam logic [2:0] st_decode = 3'd2;
  localparam logic [2:0] st_exec = 3'd3;
  localparam logic [2:0] st_mem = 3'd4;
  localparam logic [2:0] st_memm = 3'd5;
  localparam logic [2:0] st_halt = 3'd6;

  // mdr source and alu operand sources
  localparam logic [1:0] mdrs_imm = 2'd0;
  localparam logic [1:0] mdrs_ram = 2'd1;
  localparam logic [1:0] mdrs_alu = 2'd2;
  localparam logic [1:0] ops_r0 = 2'd0;
  localparam logic [1:0] ops_r1 = 2'd1;
  localparam logic [1:0] ops_mdr = 2'd2;

  // bit positions in the skp cond field
  localparam int cond_zero = 0;
  localparam int cond_neg = 1;
  localparam int cond_pos = 2;

  localparam logic [3:0] trap_uart = 4'd1;
  localparam logic [3:0] trap_page_fault = 4'd2;

  localparam logic [word_w-1:0] reset_pc_bank0 = 16'h0000;
  localparam logic [word_w-1:0] reset_pc_bank1 = 16'h0040;

endpackage

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu (
  input  logic [cpu_pkg::word_w-1:0] x,
  input  logic [cpu_pkg::word_w-1:0] y,
  input  logic [2:0]                 f,
  output logic [cpu_pkg::word_w-1:0] out
);

  always_comb begin
    case (f)
      cpu_pkg::f_add: out = x + y;
      // skp relies on this one for its compare
      cpu_pkg::f_sub: out = x - y;
      cpu_pkg::f_and: out = x & y;
      cpu_pkg::f_or: out = x | y;
      cpu_pkg::f_xor: out = x ^ y;
      cpu_pkg::f_shl: out = {x[cpu_pkg::word_w-2:0], 1'b0};
      cpu_pkg::f_shr: out = {1'b0, x[cpu_pkg::word_w-1:1]};
      default: out = x;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`default_nettype none

module regfile (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [cpu_pkg::reg_sel_w-1:0] regr0s,
  input  logic [cpu_pkg::reg_sel_w-1:0] regr1s,
  input  logic [cpu_pkg::reg_sel_w-1:0] regws,
  input  logic [cpu_pkg::word_w-1:0]    regw,
  input  logic                          we,
  input  logic                          incr_pc,
  input  logic                          bank,
  input  logic                          sr1_we,
  input  logic [cpu_pkg::word_w-1:0]    sr1_wr,
  output logic [cpu_pkg::word_w-1:0]    regr0,
  output logic [cpu_pkg::word_w-1:0]    regr1
);

  // pc of each bank kept apart from general registers 0..6
  logic [cpu_pkg::word_w-1:0] gpr [2][7];
  logic [cpu_pkg::word_w-1:0] pc [2];

  // reads come from the active bank only
  always_comb begin
    if (regr0s == cpu_pkg::reg_pc) regr0 = pc[bank];
    else regr0 = gpr[bank][regr0s];
    if (regr1s == cpu_pkg::reg_pc) regr1 = pc[bank];
    else regr1 = gpr[bank][regr1s];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < 2; b++) begin
        for (int i = 0; i < 7; i++) begin
          gpr[b][i] <= '0;
        end
      end
      pc[0] <= cpu_pkg::reset_pc_bank0;
      pc[1] <= cpu_pkg::reset_pc_bank1;
    end else begin
      if (incr_pc) pc[bank] <= pc[bank] + 16'd1;
      // an explicit pc write overrides the increment
      if (we) begin
        if (regws == cpu_pkg::reg_pc) pc[bank] <= regw;
        else gpr[bank][regws] <= regw;
      end
      // trap number lands in r1 of the interrupt bank
      if (sr1_we) gpr[1][1] <= sr1_wr;
    end
  end

endmodule

`default_nettype wire

/* verilog/irq_encoder.sv */
`default_nettype none

module irq_encoder (
  input  logic       clk,
  input  logic       reset,
  input  logic       uart_irq,
  input  logic       page_fault,
  input  logic       deassert,
  output logic       irq,
  output logic [3:0] trapnr
);

  // bit 0 uart, bit 1 page fault
  logic [1:0] pending;
  logic [1:0] clear_mask;

  // page fault outranks uart
  always_comb begin
    if (pending[1]) trapnr = cpu_pkg::trap_page_fault;
    else if (pending[0]) trapnr = cpu_pkg::trap_uart;
    else trapnr = 4'd0;
  end

  assign irq = |pending;

  always_comb begin
    clear_mask = 2'b00;
    if (deassert) begin
      clear_mask[0] = (trapnr == cpu_pkg::trap_uart);
      clear_mask[1] = (trapnr == cpu_pkg::trap_page_fault);
    end
  end

  // a fresh request beats a clear in the same cycle
  always_ff @(posedge clk) begin
    if (reset) pending <= 2'b00;
    else pending <= (pending & ~clear_mask) | {page_fault, uart_irq};
  end

endmodule

`default_nettype wire

/* verilog/decoder.sv */
`default_nettype none

module decoder (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [cpu_pkg::word_w-1:0]    instr,
  input  logic                          irq,
  output logic                          mdr_load,
  output logic                          mar_load,
  output logic                          reg_load,
  output logic                          ir_load,
  output logic                          incr_pc,
  output logic [1:0]                    mdrs,
  output logic [1:0]                    op0s,
  output logic [1:0]                    op1s,
  output logic [cpu_pkg::reg_sel_w-1:0] regr0s,
  output logic [cpu_pkg::reg_sel_w-1:0] regr1s,
  output logic [cpu_pkg::reg_sel_w-1:0] regws,
  output logic [2:0]                    alu_func,
  output logic                          cond_chk,
  output logic [2:0]                    cond,
  output logic [cpu_pkg::word_w-1:0]    imm,
  output logic                          take_irq,
  output logic                          bank,
  output logic                          re,
  output logic                          we,
  output logic                          hlt,
  output logic                          deassert,
  output logic [2:0]                    state
);

  logic [2:0] state_next;
  logic [3:0] opcode;

  assign opcode = instr[15:12];
  assign cond = instr[2:0];
  assign imm = {{(cpu_pkg::word_w-9){instr[8]}}, instr[8:0]};
  assign hlt = (state == cpu_pkg::st_halt);

  always_comb begin
    state_next = state;
    mdr_load = 1'b0;
    mar_load = 1'b0;
    reg_load = 1'b0;
    ir_load = 1'b0;
    incr_pc = 1'b0;
    re = 1'b0;
    we = 1'b0;
    take_irq = 1'b0;
    deassert = 1'b0;
    cond_chk = 1'b0;
    mdrs = cpu_pkg::mdrs_alu;
    op0s = cpu_pkg::ops_r0;
    op1s = cpu_pkg::ops_r1;
    regr0s = instr[8:6];
    regr1s = instr[5:3];
    regws = instr[11:9];
    alu_func = cpu_pkg::f_pass;

    case (state)
      cpu_pkg::st_fetch: begin
        // accept instead of fetching, then refetch from the bank 1 pc
        if (irq && !bank) begin
          take_irq = 1'b1;
          deassert = 1'b1;
        end else begin
          regr0s = cpu_pkg::reg_pc;
          op1s = cpu_pkg::ops_r0;
          mar_load = 1'b1;
          state_next = cpu_pkg::st_fetchm;
        end
      end
      cpu_pkg::st_fetchm: begin
        re = 1'b1;
        incr_pc = 1'b1;
        state_next = cpu_pkg::st_decode;
      end
      cpu_pkg::st_decode: begin
        ir_load = 1'b1;
        state_next = cpu_pkg::st_exec;
      end
      cpu_pkg::st_exec: begin
        state_next = cpu_pkg::st_fetch;
        case (opcode)
          cpu_pkg::op_alu: begin
            alu_func = instr[2:0];
            reg_load = 1'b1;
          end
          cpu_pkg::op_ldi: begin
            mdrs = cpu_pkg::mdrs_imm;
            reg_load = 1'b1;
          end
          cpu_pkg::op_ld: begin
            op1s = cpu_pkg::ops_r0;
            mar_load = 1'b1;
            state_next = cpu_pkg::st_mem;
          end
          cpu_pkg::op_st: begin
            // address to mar via op1, data to mdr through the alu
            op1s = cpu_pkg::ops_r0;
            op0s = cpu_pkg::ops_r1;
            mar_load = 1'b1;
            mdr_load = 1'b1;
            state_next = cpu_pkg::st_mem;
          end
          cpu_pkg::op_skp: begin
            alu_func = cpu_pkg::f_sub;
            cond_chk = 1'b1;
          end
          cpu_pkg::op_hlt: state_next = cpu_pkg::st_halt;
          default: state_next = cpu_pkg::st_fetch;
        endcase
      end
      cpu_pkg::st_mem: begin
        if (opcode == cpu_pkg::op_st) begin
          we = 1'b1;
          state_next = cpu_pkg::st_fetch;
        end else begin
          re = 1'b1;
          state_next = cpu_pkg::st_memm;
        end
      end
      cpu_pkg::st_memm: begin
        // read data passes the mdr mux straight into rd
        mdrs = cpu_pkg::mdrs_ram;
        mdr_load = 1'b1;
        reg_load = 1'b1;
        state_next = cpu_pkg::st_fetch;
      end
      cpu_pkg::st_halt: state_next = cpu_pkg::st_halt;
      default: state_next = cpu_pkg::st_fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cpu_pkg::st_fetch;
      bank <= 1'b0;
    end else begin
      state <= state_next;
      if (take_irq) bank <= 1'b1;
      else if (state == cpu_pkg::st_exec && opcode == cpu_pkg::op_rti) bank <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`default_nettype none

module cpu (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [cpu_pkg::word_w-1:0] ram_out,
  input  logic                       uart_intr,
  input  logic                       page_fault,
  output logic [cpu_pkg::word_w-1:0] ram_in,
  output logic [cpu_pkg::word_w-1:0] ram_addr,
  output logic                       we,
  output logic                       re,
  output logic                       hlt
);

  logic mdr_load, mar_load, reg_load, ir_load, incr_pc;
  logic cond_chk, take_irq, bank, deassert, irq, skip;
  logic incr_pc_final;
  logic [1:0] mdrs, op0s, op1s;
  logic [2:0] alu_func, cond, state;
  logic [3:0] trapnr;
  logic [cpu_pkg::reg_sel_w-1:0] regr0s, regr1s, regws;
  logic [cpu_pkg::word_w-1:0] imm, regr0, regr1, alu_out;
  logic [cpu_pkg::word_w-1:0] op0, op1, mdr_in, sr1_wr;
  logic [cpu_pkg::word_w-1:0] mdr, mar, ir;

  decoder decoder_inst (
    .clk      (clk),
    .reset    (reset),
    .instr    (ir),
    .irq      (irq),
    .mdr_load (mdr_load),
    .mar_load (mar_load),
    .reg_load (reg_load),
    .ir_load  (ir_load),
    .incr_pc  (incr_pc),
    .mdrs     (mdrs),
    .op0s     (op0s),
    .op1s     (op1s),
    .regr0s   (regr0s),
    .regr1s   (regr1s),
    .regws    (regws),
    .alu_func (alu_func),
    .cond_chk (cond_chk),
    .cond     (cond),
    .imm      (imm),
    .take_irq (take_irq),
    .bank     (bank),
    .re       (re),
    .we       (we),
    .hlt      (hlt),
    .deassert (deassert),
    .state    (state)
  );

  irq_encoder irq_encoder_inst (
    .clk        (clk),
    .reset      (reset),
    .uart_irq   (uart_intr),
    .page_fault (page_fault),
    .deassert   (deassert),
    .irq        (irq),
    .trapnr     (trapnr)
  );

  // rd is always written from the mdr mux output
  regfile regfile_inst (
    .clk     (clk),
    .reset   (reset),
    .regr0s  (regr0s),
    .regr1s  (regr1s),
    .regws   (regws),
    .regw    (mdr_in),
    .we      (reg_load),
    .incr_pc (incr_pc_final),
    .bank    (bank),
    .sr1_we  (take_irq),
    .sr1_wr  (sr1_wr),
    .regr0   (regr0),
    .regr1   (regr1)
  );

  alu alu_inst (
    .x   (op0),
    .y   (op1),
    .f   (alu_func),
    .out (alu_out)
  );

  // bus select muxes
  always_comb begin
    case (mdrs)
      cpu_pkg::mdrs_ram: mdr_in = ram_out;
      cpu_pkg::mdrs_alu: mdr_in = alu_out;
      default: mdr_in = imm;
    endcase
    case (op0s)
      cpu_pkg::ops_r1: op0 = regr1;
      cpu_pkg::ops_mdr: op0 = mdr;
      default: op0 = regr0;
    endcase
    case (op1s)
      cpu_pkg::ops_r0: op1 = regr0;
      cpu_pkg::ops_mdr: op1 = mdr;
      default: op1 = regr1;
    endcase
  end

  // skp compares rs0 - rs1 against the cond bits
  always_comb begin
    skip = 1'b0;
    if (cond_chk) begin
      if (alu_out == '0) skip = cond[cpu_pkg::cond_zero];
      else if (alu_out[cpu_pkg::word_w-1]) skip = cond[cpu_pkg::cond_neg];
      else skip = cond[cpu_pkg::cond_pos];
    end
  end

  assign incr_pc_final = incr_pc | skip;
  assign sr1_wr = {{(cpu_pkg::word_w-4){1'b0}}, trapnr};

  // mar takes operand 1 so st can move data through the alu alongside
  always_ff @(posedge clk) begin
    if (mdr_load) mdr <= mdr_in;
    if (mar_load) mar <= op1;
    if (ir_load) ir <= ram_out;
  end

  assign ram_addr = mar;
  assign ram_in = mdr;

endmodule

`default_nettype wire

/* test/cpu_asserts.sv */
`default_nettype none

module cpu_asserts (
  input logic       clk,
  input logic       reset,
  input logic       re,
  input logic       we,
  input logic       hlt,
  input logic       deassert,
  input logic [2:0] state
);
  timeunit 1ns;
  timeprecision 1ps;

  // single-port ram, one access per cycle
  assert property (@(posedge clk) disable iff (reset) !(re && we))
    else $error("re and we high in the same cycle");

  assert property (@(posedge clk) disable iff (reset) we |-> state == cpu_pkg::st_mem)
    else $error("we outside st_mem");

  assert property (@(posedge clk) disable iff (reset) deassert |=> !deassert)
    else $error("deassert longer than one cycle");

  // only reset leaves the halt state
  assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
    else $error("hlt dropped without reset");

endmodule

bind cpu cpu_asserts cpu_asserts_inst (
  .clk      (clk),
  .reset    (reset),
  .re       (re),
  .we       (we),
  .hlt      (hlt),
  .deassert (deassert),
  .state    (state)
);

`default_nettype wire

/* test/cpu_tb.sv */
`default_nettype none

module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int period = 100;
  localparam int wait_limit = 2000;

  logic clk = 1'b0;
  logic reset;
  logic uart_intr = 1'b0;
  logic page_fault = 1'b0;
  logic [15:0] ram_out = '0;
  logic [15:0] ram_in, ram_addr;
  logic we, re, hlt;

  // file image: program at 0x000, schedule at 0x100, store log at 0x180
  logic [15:0] img [512];
  logic [15:0] ram [256];
  logic [15:0] sched_cycle [$];
  logic [1:0] sched_line [$];
  logic [15:0] exp_addr [$];
  logic [15:0] exp_data [$];
  logic [15:0] got_addr [$];
  logic [15:0] got_data [$];
  logic [15:0] op_a, op_b;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycle = 0;
  int late_access = 0;

  cpu cpu_inst (
    .clk        (clk),
    .reset      (reset),
    .ram_out    (ram_out),
    .uart_intr  (uart_intr),
    .page_fault (page_fault),
    .ram_in     (ram_in),
    .ram_addr   (ram_addr),
    .we         (we),
    .re         (re),
    .hlt        (hlt)
  );

  always #(period / 2) clk = ~clk;

  // ram model, read data appears the cycle after re
  always @(posedge clk) begin
    logic rd_req;
    logic wr_req;
    logic [7:0] a;
    rd_req = re;
    wr_req = we;
    a = ram_addr[7:0];
    if (hlt && (rd_req || wr_req)) late_access++;
    if (wr_req) begin
      ram[a] = ram_in;
      got_addr.push_back(ram_addr);
      got_data.push_back(ram_in);
    end
    #1;
    if (rd_req) ram_out = ram[a];
  end

  // interrupt lines pulse for one cycle at the scheduled cycle
  always @(posedge clk) begin
    logic [1:0] lines;
    lines = 2'b00;
    if (!reset) cycle++;
    for (int k = 0; k < sched_cycle.size(); k++) begin
      if (sched_cycle[k] == 16'(cycle)) lines = lines | sched_line[k];
    end
    #1;
    uart_intr = lines[0];
    page_fault = lines[1];
  end

  function automatic logic [15:0] alu_ref(input logic [2:0] f, input logic [15:0] a,
                                          input logic [15:0] b);
    case (f)
      3'd0: return a + b;
      3'd1: return a - b;
      3'd2: return a & b;
      3'd3: return a | b;
      3'd4: return a ^ b;
      3'd5: return a << 1;
      3'd6: return a >> 1;
      default: return a;
    endcase
  endfunction

  task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors > errs_before) begin
      tests_failed++;
      $display("test %s failed", name);
    end else begin
      $display("test %s passed", name);
    end
  endtask

  task automatic store_test(input string name, input int first, input int last,
                            input bit from_alu);
    int errs_before;
    int t;
    logic [15:0] exp;
    errs_before = errors;
    t = 0;
    while (got_addr.size() <= last && t < wait_limit) begin
      @(negedge clk);
      t++;
    end
    if (got_addr.size() <= last) begin
      $display("store %0d never arrived in test %s", last, name);
      errors++;
    end else begin
      for (int i = first; i <= last; i++) begin
        exp = from_alu ? alu_ref(3'(i - first), op_a, op_b) : exp_data[i];
        check("ram_addr", got_addr[i], exp_addr[i]);
        check("ram_in", got_data[i], exp);
      end
    end
    report_test(name, errs_before);
  endtask

  task automatic halt_test();
    int errs_before;
    int t;
    errs_before = errors;
    t = 0;
    while (!hlt && t < wait_limit) begin
      @(negedge clk);
      t++;
    end
    if (!hlt) begin
      $display("hlt never rose");
      errors++;
    end else begin
      repeat (20) @(negedge clk);
      if (late_access != 0) begin
        $display("memory access seen after hlt");
        errors++;
      end
      check("store_count", 16'(got_addr.size()), 16'(exp_addr.size()));
    end
    report_test("hlt", errs_before);
  endtask

  initial begin
    int k;
    reset = 1'b1;
    $readmemh("test/program_input.txt", img);
    for (int i = 0; i < 256; i++) ram[i] = img[i];
    k = 'h100;
    while (k < 'h180 && img[k] != 16'hffff) begin
      sched_cycle.push_back(img[k]);
      sched_line.push_back(img[k + 1][1:0]);
      k += 2;
    end
    k = 'h180;
    while (k < 'h200 && img[k] != 16'hffff) begin
      exp_addr.push_back(img[k]);
      exp_data.push_back(img[k + 1]);
      k += 2;
    end
    // alu operands come from the two leading ldi immediates
    op_a = {{7{img[0][8]}}, img[0][8:0]};
    op_b = {{7{img[1][8]}}, img[1][8:0]};
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;

    store_test("alu_ldi", 0, 7, 1'b1);
    store_test("ld_st", 8, 8, 1'b0);
    store_test("skp", 9, 11, 1'b0);
    store_test("interrupts", 12, 15, 1'b0);
    halt_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog for the whole run
  initial begin
    #(period * 20000);
    $display("simulation ran past its time limit");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/regfile.sv
verilog/irq_encoder.sv
verilog/decoder.sv
verilog/cpu.sv
test/cpu_asserts.sv
test/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module cpu_tb -o cpu_sim

# the search fails the script unless the pass line was printed
./obj_dir/cpu_sim | tee /dev/stderr | grep -c "NO ERRORS" > /dev/null
echo "simulation passed"

/* test/program_input.txt */
// program words from 0x000, handler at 0x040, data word at 0x0f0
// 0x100: interrupt schedule, cycle then lines (bit0 uart, bit1 page fault), ffff ends
// 0x180: expected stores, address then data, ffff ends
@000
13F3 1425 16A0 1A01
0850 30E0 06E8 0851 30E0 06E8 0852 30E0 06E8 0853 30E0 06E8
0854 30E0 06E8 0855 30E0 06E8 0856 30E0 06E8 0857 30E0 06E8
1CF0 2980 090C 30E0 06E8
4169 30D8 06E8 416A 30D8 06E8 4052 30D8 06E8
4054 30D8 06E8 408C 30D8 06E8 4089 30D8 06E8
1E50
@040
1480 3088 6000 1481 3088 6000
@050
7000 7000 7000 7000 7000 7000 7000 7000
7000 7000 7000 7000 7000 7000 7000 7000
30D8 06E8 30D8 5000
@0F0
1234
@100
00E6 0003
FFFF 0000
@180
00A0 0018 00A1 FFCE 00A2 0021 00A3 FFF7
00A4 FFD6 00A5 FFE6 00A6 7FF9 00A7 FFF3
00A8 EDC7
00AA 00AA 00AC 00AC 00AE 00AE
0080 0002 0081 0001 00AF 00AF 00B0 00B0
FFFF 0000
